/* source/eeprom_pkg.sv */
package eeprom_pkg;

    // bit engine operations, start doubles as repeated start
    localparam logic [1:0] OP_START = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_READ  = 2'd2;
    localparam logic [1:0] OP_STOP  = 2'd3;

    localparam logic [3:0] DEVICE_CODE = 4'b1010; // 24cxx family

    // apb register offsets
    localparam logic [3:0] REG_ADDR   = 4'h0;
    localparam logic [3:0] REG_WDATA  = 4'h4;
    localparam logic [3:0] REG_CMD    = 4'h8; // bit 0 go, bit 1 read
    localparam logic [3:0] REG_STATUS = 4'hC; // busy, done, nack, byte in 15:8

    localparam int CMD_GO_BIT   = 0;
    localparam int CMD_READ_BIT = 1;

    // one byte on the wire, seen as control byte or raw byte
    typedef union packed
    {
        struct packed
        {
            logic [3:0] dev;
            logic [2:0] blk; // address bits 10:8
            logic       rd;
        } ctrl;
        logic [7:0] data;
    } i2c_frame_u;

endpackage

/* source/i2c_bit_engine.sv */
module i2c_bit_engine #(
    parameter int CLK_DIV = 4
)
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   op_valid,
    input  logic [1:0]             op_code,
    input  eeprom_pkg::i2c_frame_u op_frame,
    output logic                   op_ready,
    output logic                   op_done,
    output logic                   op_ack,
    output logic [7:0]             op_rx,
    output logic                   scl,
    output logic                   sda_oe,
    input  logic                   sda_in
);

    localparam int QW = $clog2(CLK_DIV);

    logic          busy;
    logic [1:0]    op;
    logic [7:0]    shreg;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;  // 0 low, 1 and 2 high, 3 low
    logic [3:0]    bitcnt; // 8 is the ack slot
    logic          last_bit;

    assign op_ready = !busy;
    assign last_bit = (op == eeprom_pkg::OP_START) || (op == eeprom_pkg::OP_STOP)
                      || (bitcnt == 4'd8);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op      <= eeprom_pkg::OP_STOP;
            qcnt    <= '0;
            phase   <= 2'd0;
            bitcnt  <= 4'd0;
            op_done <= 1'b0;
            scl     <= 1'b1; // bus released
            sda_oe  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (op_valid)
                begin
                    busy   <= 1'b1;
                    op     <= op_code;
                    shreg  <= op_frame.data;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitcnt <= 4'd0;
                    // first quarter, scl untouched
                    case (op_code)
                        eeprom_pkg::OP_STOP:  sda_oe <= 1'b1;
                        eeprom_pkg::OP_WRITE: sda_oe <= !op_frame.data[7];
                        default:              sda_oe <= 1'b0;
                    endcase
                end
            end
            else if (qcnt != QW'(CLK_DIV - 1))
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0: scl <= 1'b1;
                    2'd1:
                    begin
                        // midpoint of scl high
                        if (op == eeprom_pkg::OP_START)
                            sda_oe <= 1'b1; // start edge
                        if (op == eeprom_pkg::OP_STOP)
                            sda_oe <= 1'b0; // stop edge
                        if (op == eeprom_pkg::OP_READ && bitcnt != 4'd8)
                            op_rx <= {op_rx[6:0], sda_in};
                        if (op == eeprom_pkg::OP_WRITE && bitcnt == 4'd8)
                            op_ack <= !sda_in;
                    end
                    2'd2:
                    begin
                        if (op != eeprom_pkg::OP_STOP)
                            scl <= 1'b0;
                    end
                    default:
                    begin
                        if (last_bit)
                        begin
                            busy    <= 1'b0;
                            op_done <= 1'b1;
                        end
                        else
                        begin
                            bitcnt <= bitcnt + 4'd1;
                            shreg  <= {shreg[6:0], 1'b0};
                            // release for ack slot, reads always released (nack at the end)
                            sda_oe <= (op == eeprom_pkg::OP_WRITE) && (bitcnt != 4'd7)
                                      && !shreg[6];
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* source/eeprom_byte_seq.sv */
module eeprom_byte_seq
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   cmd_go,
    input  logic                   cmd_read,
    input  logic [10:0]            cmd_addr,
    input  logic [7:0]             cmd_wdata,
    output logic                   seq_busy,
    output logic                   seq_done,
    output logic                   seq_nack,
    output logic [7:0]             seq_rdata,
    output logic                   op_valid,
    output logic [1:0]             op_code,
    output eeprom_pkg::i2c_frame_u op_frame,
    input  logic                   op_ready,
    input  logic                   op_done,
    input  logic                   op_ack,
    input  logic [7:0]             op_rx
);

    localparam logic [3:0] S_IDLE   = 4'd0;
    localparam logic [3:0] S_START  = 4'd1;
    localparam logic [3:0] S_CTRL   = 4'd2;
    localparam logic [3:0] S_ADDR   = 4'd3;
    localparam logic [3:0] S_DATA   = 4'd4;
    localparam logic [3:0] S_RSTART = 4'd5;
    localparam logic [3:0] S_RCTRL  = 4'd6;
    localparam logic [3:0] S_READ   = 4'd7;
    localparam logic [3:0] S_STOP   = 4'd8;

    logic [3:0]  state;
    logic        rd_q;
    logic [10:0] addr_q;
    logic [7:0]  wdata_q;

    // operation and frame follow the state, so they hold until accepted
    always_comb
    begin
        op_code       = eeprom_pkg::OP_WRITE;
        op_frame.data = addr_q[7:0];
        case (state)
            S_START, S_RSTART: op_code = eeprom_pkg::OP_START;
            S_CTRL, S_RCTRL:
            begin
                op_frame.ctrl.dev = eeprom_pkg::DEVICE_CODE;
                op_frame.ctrl.blk = addr_q[10:8];
                op_frame.ctrl.rd  = (state == S_RCTRL);
            end
            S_DATA: op_frame.data = wdata_q;
            S_READ: op_code = eeprom_pkg::OP_READ;
            S_STOP: op_code = eeprom_pkg::OP_STOP;
            default: op_code = eeprom_pkg::OP_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_go && state == S_IDLE)
        begin
            rd_q    <= cmd_read;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            op_valid  <= 1'b0;
            seq_busy  <= 1'b0;
            seq_done  <= 1'b0;
            seq_nack  <= 1'b0;
            seq_rdata <= 8'h00;
        end
        else
        begin
            seq_done <= 1'b0;
            if (op_done && state == S_READ)
                seq_rdata <= op_rx;
            if (state == S_IDLE)
            begin
                if (cmd_go)
                begin
                    state    <= S_START;
                    op_valid <= 1'b1;
                    seq_busy <= 1'b1;
                    seq_nack <= 1'b0;
                end
            end
            else if (op_done)
            begin
                op_valid <= 1'b1; // next op goes out one cycle later
                case (state)
                    S_START:  state <= S_CTRL;
                    S_RSTART: state <= S_RCTRL;
                    S_CTRL, S_ADDR, S_DATA, S_RCTRL:
                    begin
                        if (!op_ack)
                        begin
                            seq_nack <= 1'b1; // abort, close the bus
                            state    <= S_STOP;
                        end
                        else if (state == S_CTRL)
                            state <= S_ADDR;
                        else if (state == S_ADDR)
                            state <= rd_q ? S_RSTART : S_DATA;
                        else if (state == S_RCTRL)
                            state <= S_READ;
                        else
                            state <= S_STOP;
                    end
                    S_READ: state <= S_STOP;
                    default:
                    begin
                        // stop finished
                        op_valid <= 1'b0;
                        seq_busy <= 1'b0;
                        seq_done <= 1'b1;
                        state    <= S_IDLE;
                    end
                endcase
            end
            else if (op_valid && op_ready)
                op_valid <= 1'b0;
        end
    end

endmodule

/* source/eeprom_apb_regs.sv */
module eeprom_apb_regs
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        cmd_go,
    output logic        cmd_read,
    output logic [10:0] cmd_addr,
    output logic [7:0]  cmd_wdata,
    input  logic        seq_busy,
    input  logic        seq_done,
    input  logic        seq_nack,
    input  logic [7:0]  seq_rdata
);

    logic       wr_en;
    logic       go_req;
    logic       busy;
    logic       done;
    logic       nack;
    logic [7:0] rd_byte;

    assign pready  = 1'b1; // no wait states
    assign wr_en   = psel && penable && pwrite;
    assign go_req  = wr_en && (paddr == eeprom_pkg::REG_CMD) && pwdata[eeprom_pkg::CMD_GO_BIT];
    assign pslverr = go_req && busy; // go refused while a command runs

    // payload registers, sequencer copies them at launch
    always_ff @(posedge CLK)
    begin
        if (wr_en && paddr == eeprom_pkg::REG_ADDR)
            cmd_addr <= pwdata[10:0];
        if (wr_en && paddr == eeprom_pkg::REG_WDATA)
            cmd_wdata <= pwdata[7:0];
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cmd_go   <= 1'b0;
            cmd_read <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
            rd_byte  <= 8'h00;
        end
        else
        begin
            cmd_go <= go_req && !busy;
            if (wr_en && paddr == eeprom_pkg::REG_CMD && !pslverr)
                cmd_read <= pwdata[eeprom_pkg::CMD_READ_BIT];

            if (go_req && !busy)
            begin
                busy <= 1'b1;
                done <= 1'b0;
                nack <= 1'b0;
            end
            else if (seq_done)
            begin
                busy    <= 1'b0;
                done    <= 1'b1;
                nack    <= seq_nack;
                rd_byte <= seq_rdata; // unchanged by sequencer on nack
            end
        end
    end

    always_comb
    begin
        prdata = 32'h0;
        case (paddr)
            eeprom_pkg::REG_ADDR:   prdata = {21'h0, cmd_addr};
            eeprom_pkg::REG_WDATA:  prdata = {24'h0, cmd_wdata};
            eeprom_pkg::REG_CMD:    prdata = {30'h0, cmd_read, 1'b0}; // go reads back 0
            eeprom_pkg::REG_STATUS: prdata = {16'h0, rd_byte, 5'h0, nack, done, busy || seq_busy};
            default:                prdata = 32'h0;
        endcase
    end

endmodule

/* source/eeprom_ctrl_top.sv */
module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4 // scl quarter period in clk cycles
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        PSEL,
    input  logic        PENABLE,
    input  logic        PWRITE,
    input  logic [3:0]  PADDR,
    input  logic [31:0] PWDATA,
    output logic [31:0] PRDATA,
    output logic        PREADY,
    output logic        PSLVERR,
    output logic        SCL,
    output logic        SDA_OE,
    input  logic        SDA_IN
);

    logic                   cmd_go;
    logic                   cmd_read;
    logic [10:0]            cmd_addr;
    logic [7:0]             cmd_wdata;
    logic                   seq_busy;
    logic                   seq_done;
    logic                   seq_nack;
    logic [7:0]             seq_rdata;
    logic                   op_valid;
    logic [1:0]             op_code;
    eeprom_pkg::i2c_frame_u op_frame;
    logic                   op_ready;
    logic                   op_done;
    logic                   op_ack;
    logic [7:0]             op_rx;

    eeprom_apb_regs u_regs
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (PSEL),
        .penable   (PENABLE),
        .pwrite    (PWRITE),
        .paddr     (PADDR),
        .pwdata    (PWDATA),
        .prdata    (PRDATA),
        .pready    (PREADY),
        .pslverr   (PSLVERR),
        .cmd_go    (cmd_go),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .seq_busy  (seq_busy),
        .seq_done  (seq_done),
        .seq_nack  (seq_nack),
        .seq_rdata (seq_rdata)
    );

    eeprom_byte_seq u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_go    (cmd_go),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .seq_busy  (seq_busy),
        .seq_done  (seq_done),
        .seq_nack  (seq_nack),
        .seq_rdata (seq_rdata),
        .op_valid  (op_valid),
        .op_code   (op_code),
        .op_frame  (op_frame),
        .op_ready  (op_ready),
        .op_done   (op_done),
        .op_ack    (op_ack),
        .op_rx     (op_rx)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_valid (op_valid),
        .op_code  (op_code),
        .op_frame (op_frame),
        .op_ready (op_ready),
        .op_done  (op_done),
        .op_ack   (op_ack),
        .op_rx    (op_rx),
        .scl      (SCL),
        .sda_oe   (SDA_OE),
        .sda_in   (SDA_IN)
    );

endmodule

/* verif/eeprom_model.sv */
module eeprom_model
(
    input  logic        scl,
    input  logic        sda,
    input  logic        nack_en,
    input  logic [10:0] exp_addr,
    output logic        sda_pull,
    output logic        err
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]             mem [0:2047];
    logic [7:0]             shreg;
    logic [7:0]             tx_byte;
    logic [2:0]             blk;
    logic [10:0]            addr;
    logic                   prev_scl;
    logic                   prev_sda;
    logic                   skip_fall;
    logic                   addr_done;
    logic                   acked;
    logic                   tx_next;
    logic                   master_ack;
    int                     state; // 0 idle, 1 receive, 2 transmit
    int                     bitcnt;
    int                     byte_idx;
    int                     starts;
    eeprom_pkg::i2c_frame_u frame;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 7 + (i >> 8));
        sda_pull   = 1'b0;
        err        = 1'b0;
        state      = 0;
        bitcnt     = 0;
        byte_idx   = 0;
        starts     = 0;
        skip_fall  = 1'b0;
        addr_done  = 1'b0;
        acked      = 1'b0;
        tx_next    = 1'b0;
        master_ack = 1'b0;
        addr       = '0;
        blk        = '0;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && prev_scl === 1'b1 && sda !== prev_sda && prev_sda !== 1'bx)
        begin
            // sda edge with scl high must sit on a byte boundary
            assert (bitcnt == 0)
            else
            begin
                $display("SDA changed while SCL was high in the middle of a byte");
                err = 1'b1;
            end
            if (sda === 1'b0)
            begin
                starts++; // start or repeated start
                state     = 1;
                bitcnt    = 0;
                byte_idx  = 0;
                skip_fall = 1'b1;
                sda_pull  = 1'b0;
            end
            else
            begin
                state     = 0;
                addr_done = 1'b0;
                sda_pull  = 1'b0;
            end
        end
        else if (scl === 1'b1 && prev_scl === 1'b0)
        begin
            if (state == 1 && bitcnt < 8)
                shreg = {shreg[6:0], sda};
            if (state == 2 && bitcnt == 8)
                master_ack = (sda === 1'b0);
        end
        else if (scl === 1'b0 && prev_scl === 1'b1)
        begin
            if (skip_fall)
                skip_fall = 1'b0; // scl fall that closes the start
            else if (state == 1)
            begin
                if (bitcnt < 7)
                    bitcnt++;
                else if (bitcnt == 7)
                begin
                    frame.data = shreg;
                    acked      = !nack_en;
                    if (byte_idx == 0)
                    begin
                        assert (frame.ctrl.dev == eeprom_pkg::DEVICE_CODE)
                        else
                        begin
                            $display("[FAIL] ctrl.dev got %h expected %h", frame.ctrl.dev,
                                     eeprom_pkg::DEVICE_CODE);
                            err = 1'b1;
                        end
                        assert (frame.ctrl.blk == exp_addr[10:8])
                        else
                        begin
                            $display("[FAIL] ctrl.blk got %h expected %h", frame.ctrl.blk,
                                     exp_addr[10:8]);
                            err = 1'b1;
                        end
                        assert (frame.ctrl.rd == addr_done)
                        else
                        begin
                            $display("[FAIL] ctrl.rd got %h expected %h", frame.ctrl.rd,
                                     addr_done);
                            err = 1'b1;
                        end
                        blk     = frame.ctrl.blk;
                        tx_next = frame.ctrl.rd;
                    end
                    else if (byte_idx == 1)
                    begin
                        addr      = {blk, shreg};
                        addr_done = acked;
                    end
                    else if (acked)
                        mem[addr] = shreg; // write completes at once
                    byte_idx++;
                    sda_pull = acked;
                    bitcnt   = 8;
                end
                else
                begin
                    sda_pull = 1'b0;
                    bitcnt   = 0;
                    if (!acked)
                        state = 0;
                    else if (byte_idx == 1 && tx_next)
                    begin
                        state    = 2;
                        tx_byte  = mem[addr];
                        sda_pull = !tx_byte[7];
                    end
                end
            end
            else if (state == 2)
            begin
                if (bitcnt < 7)
                begin
                    bitcnt++;
                    sda_pull = !tx_byte[7 - bitcnt];
                end
                else if (bitcnt == 7)
                begin
                    sda_pull = 1'b0;
                    bitcnt   = 8;
                end
                else
                begin
                    assert (!master_ack)
                    else
                    begin
                        $display("controller acknowledged the last read byte");
                        err = 1'b1;
                    end
                    bitcnt = 0;
                    state  = 0;
                end
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

/* verif/tb_eeprom_ctrl.sv */
module tb_eeprom_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV = 4;
    localparam int PAIRS   = 12;
    localparam int N_CMD   = 2 * PAIRS + 2;

    logic        CLK;
    logic        RESET;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [3:0]  PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    logic        SCL;
    logic        SDA_OE;
    logic        sda;
    logic        pull;
    logic        nack_en;
    logic        model_err;
    logic [10:0] cur_addr;
    logic [31:0] st;
    logic [7:0]  data;
    logic [7:0]  last_rd;
    logic [7:0]  old;
    logic        err;
    int          starts_before;

    assign sda = !(SDA_OE || pull); // open drain with pull-up

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) uut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .SCL     (SCL),
        .SDA_OE  (SDA_OE),
        .SDA_IN  (sda)
    );

    eeprom_model m
    (
        .scl      (SCL),
        .sda      (sda),
        .nack_en  (nack_en),
        .exp_addr (cur_addr),
        .sda_pull (pull),
        .err      (model_err)
    );

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic apb_write(input logic [3:0] a, input logic [31:0] d, output logic slverr);
        @(posedge CLK);
        #1;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b1;
        PADDR   = a;
        PWDATA  = d;
        @(posedge CLK);
        #1;
        PENABLE = 1'b1;
        #3 slverr = PSLVERR; // access phase, before the completing edge
        @(posedge CLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] a, output logic [31:0] d);
        @(posedge CLK);
        #1;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = a;
        @(posedge CLK);
        #1;
        PENABLE = 1'b1;
        #3 d = PRDATA;
        @(posedge CLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic start_cmd(input logic [10:0] a, input logic [7:0] d, input logic rd);
        logic e;
        cur_addr = a;
        apb_write(eeprom_pkg::REG_ADDR, 32'(a), e);
        apb_write(eeprom_pkg::REG_WDATA, 32'(d), e);
        apb_write(eeprom_pkg::REG_CMD, {30'h0, rd, 1'b1}, e);
        check_eq("PSLVERR", 32'(e), 32'h0);
    endtask

    // poll until done with busy clear, then the bus must be idle
    task automatic wait_done(output logic [31:0] status);
        do
            apb_read(eeprom_pkg::REG_STATUS, status);
        while (!(status[1] && !status[0]));
        check_eq("SCL", 32'(SCL), 32'h1);
        check_eq("SDA", 32'(sda), 32'h1);
    endtask

    initial
    begin
        CLK = 1'b0;
        forever
            #4 CLK = !CLK;
    end

    ready_always: assert property (@(posedge CLK) PREADY)
    else
    begin
        $display("[FAIL] PREADY got %h expected 1", PREADY);
        abort_run();
    end

    initial
    begin
        wait (model_err === 1'b1);
        $display("EEPROM model reported a bus error");
        abort_run();
    end

    initial
    begin
        #(N_CMD * (40 * 4 * CLK_DIV * 3 + 50) * 8);
        $display("timeout, a command never finished");
        abort_run();
    end

    initial
    begin
        void'($urandom(32'hdc20ebcf));
        RESET    = 1'b1;
        PSEL     = 1'b0;
        PENABLE  = 1'b0;
        PWRITE   = 1'b0;
        PADDR    = 4'h0;
        PWDATA   = 32'h0;
        nack_en  = 1'b0;
        cur_addr = 11'h0;
        repeat (3) @(posedge CLK);
        #1;
        check_eq("SCL", 32'(SCL), 32'h1);
        check_eq("SDA_OE", 32'(SDA_OE), 32'h0);
        check_eq("PSLVERR", 32'(PSLVERR), 32'h0);
        repeat (5) @(posedge CLK);
        #1 RESET = 1'b0;
        apb_read(eeprom_pkg::REG_STATUS, st);
        check_eq("REG_STATUS", st, 32'h0);
        check_eq("SCL", 32'(SCL), 32'h1);

        for (int i = 0; i < PAIRS; i++)
        begin
            cur_addr = 11'($urandom);
            data     = 8'($urandom);
            start_cmd(cur_addr, data, 1'b0);
            wait_done(st);
            check_eq("status nack", 32'(st[2]), 32'h0);
            check_eq("model mem", 32'(m.mem[cur_addr]), 32'(data));
            start_cmd(cur_addr, 8'h00, 1'b1);
            wait_done(st);
            check_eq("status nack", 32'(st[2]), 32'h0);
            check_eq("read byte", 32'(st[15:8]), 32'(data));
            last_rd = data;
        end

        // second go while busy is refused
        starts_before = m.starts;
        data = 8'($urandom);
        start_cmd(11'($urandom), data, 1'b0);
        repeat (20) @(posedge CLK);
        apb_write(eeprom_pkg::REG_CMD, 32'h3, err);
        check_eq("PSLVERR", 32'(err), 32'h1);
        wait_done(st);
        check_eq("model mem", 32'(m.mem[cur_addr]), 32'(data));
        repeat (200) @(posedge CLK);
        check_eq("start count", 32'(m.starts - starts_before), 32'h1);
        apb_read(eeprom_pkg::REG_STATUS, st);
        check_eq("status busy", 32'(st[0]), 32'h0);

        nack_en = 1'b1;
        cur_addr = 11'($urandom);
        old = m.mem[cur_addr];
        start_cmd(cur_addr, ~old, 1'b0);
        wait_done(st);
        check_eq("status nack", 32'(st[2]), 32'h1);
        check_eq("read byte", 32'(st[15:8]), 32'(last_rd)); // kept from the last read
        check_eq("model mem", 32'(m.mem[cur_addr]), 32'(old));
        nack_en = 1'b0;

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* eeprom_ctrl_top.f */
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_byte_seq.sv
source/eeprom_apb_regs.sv
source/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_ctrl.sv

/* Makefile */
TOP := tb_eeprom_ctrl

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f eeprom_ctrl_top.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

lint:
	verilator --lint-only --timing --assert -f eeprom_ctrl_top.f --top-module $(TOP)
	verilator --lint-only source/eeprom_pkg.sv source/i2c_bit_engine.sv \
		source/eeprom_byte_seq.sv source/eeprom_apb_regs.sv source/eeprom_ctrl_top.sv \
		--top-module eeprom_ctrl_top

clean:
	rm -rf obj_dir
